// ==== common/reg_bus_pkg.sv ====
package reg_bus_pkg;

    // Data word and address widths of the register-native bus
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 6;

    // One word per address
    localparam int MEM_ENTRIES = 1 << ADDR_WIDTH;

    // One bus request, held steady by the requester while req_vld is high
    typedef struct packed {
        logic                  wr_en;
        logic                  rd_en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wr_data;
    } bus_req_t;

endpackage

// ==== common/mem_cmd_pkg.sv ====
package mem_cmd_pkg;
    import reg_bus_pkg::*;

    // Command queue sizing
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CMD_PTR_WIDTH = $clog2(CMD_FIFO_DEPTH);
    localparam int CMD_CNT_WIDTH = $clog2(CMD_FIFO_DEPTH + 1);

    // Cycles to wait for an acknowledge before giving up
    localparam int ACK_TIMEOUT = 8;
    localparam int ACK_CNT_WIDTH = $clog2(ACK_TIMEOUT);

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_ADD   = 2'd2
    } mem_op_e;

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_REQ     = 3'd1,
        S_RECOVER = 3'd2,
        S_ADD_WR  = 3'd3,
        S_RESP    = 3'd4
    } ctrl_state_e;

    typedef struct packed {
        mem_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] operand;
    } mem_cmd_t;

    typedef struct packed {
        mem_op_e               op;
        logic                  error;
        logic [DATA_WIDTH-1:0] data;
    } mem_rsp_t;

endpackage

// ==== hw/ext_mem/ext_mem.sv ====
`timescale 1ns/1ps

module ext_mem
    import reg_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_vld,
    input  bus_req_t              bus_req,
    input  logic                  ack_fault,
    output logic                  ack_vld,
    output logic [DATA_WIDTH-1:0] rd_data
);

    logic                  req_vld_ff;
    bus_req_t              req_ff;
    logic                  req_pend;
    logic                  new_req;
    logic                  ack_now;
    logic [DATA_WIDTH-1:0] mem [MEM_ENTRIES];

    // A request is new when valid rises or the held request changes
    assign new_req = req_vld && (!req_vld_ff || (bus_req != req_ff));

    // Fault injection holds back the access and its acknowledge
    assign ack_now = req_pend && (req_ff.wr_en || req_ff.rd_en) && !ack_fault;

    // All request fields are registered before use
    always_ff @(posedge clk) begin
        req_ff <= bus_req;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_vld_ff <= 1'b0;
            req_pend <= 1'b0;
        end else begin
            req_vld_ff <= req_vld;
            // Dropping req_vld abandons whatever is still pending
            if (new_req) begin
                req_pend <= 1'b1;
            end else if (!req_vld || ack_now) begin
                req_pend <= 1'b0;
            end
        end
    end

    // Array contents survive reset
    always_ff @(posedge clk) begin
        if (ack_now && req_ff.wr_en) begin
            mem[req_ff.addr] <= req_ff.wr_data;
        end
    end

    // Read data only in the ack cycle, zero otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_vld <= 1'b0;
            rd_data <= '0;
        end else begin
            ack_vld <= ack_now;
            if (ack_now && req_ff.rd_en) begin
                rd_data <= mem[req_ff.addr];
            end else begin
                rd_data <= '0;
            end
        end
    end

    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (reset)
        req_vld |-> !(bus_req.wr_en && bus_req.rd_en)
    ) else $error("ext_mem: read and write enabled in one request");

endmodule

// ==== hw/mem_ctrl/mem_access_ctrl.sv ====
`timescale 1ns/1ps

module mem_access_ctrl
    import reg_bus_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  deq_valid,
    input  mem_cmd_t              deq_cmd,
    input  logic                  ack_vld,
    input  logic [DATA_WIDTH-1:0] rd_data,
    output logic                  deq_pop,
    output logic                  req_vld,
    output bus_req_t              bus_req,
    output logic                  rsp_valid,
    output mem_rsp_t              rsp
);

    ctrl_state_e              state;
    mem_cmd_t                 cmd_q;
    logic [ACK_CNT_WIDTH-1:0] tmo_cnt;
    logic [DATA_WIDTH-1:0]    data_q;
    logic                     err_q;
    logic                     in_req;
    logic                     tmo_hit;
    logic                     add_rd_done;

    // Take a new command only when nothing is in flight
    assign deq_pop = (state == S_IDLE) && deq_valid;

    assign in_req = (state == S_REQ) || (state == S_ADD_WR);

    // Last wait cycle passed without an acknowledge
    assign tmo_hit = in_req && !ack_vld
                     && (tmo_cnt == ACK_CNT_WIDTH'(ACK_TIMEOUT - 1));

    // Read phase of a read-add-write has returned the old word
    assign add_rd_done = (state == S_REQ) && ack_vld && (cmd_q.op == OP_ADD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            req_vld <= 1'b0;
            tmo_cnt <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (deq_pop) begin
                        state <= S_REQ;
                        req_vld <= 1'b1;
                        tmo_cnt <= '0;
                    end
                end
                S_REQ, S_ADD_WR: begin
                    if (add_rd_done) begin
                        // Write phase follows straight on, req_vld stays high
                        state <= S_ADD_WR;
                        tmo_cnt <= '0;
                    end else if (ack_vld || tmo_hit) begin
                        state <= S_RECOVER;
                        req_vld <= 1'b0;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                S_RECOVER: begin
                    // Memory has seen req_vld low, so no stale ack can follow
                    state <= S_RESP;
                    rsp_valid <= 1'b1;
                end
                S_RESP: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Command, bus request and response payload
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (deq_pop) begin
                    cmd_q <= deq_cmd;
                    err_q <= 1'b0;
                    data_q <= '0;
                    bus_req.wr_en <= (deq_cmd.op == OP_WRITE);
                    bus_req.rd_en <= (deq_cmd.op != OP_WRITE);
                    bus_req.addr <= deq_cmd.addr;
                    if (deq_cmd.op == OP_WRITE) begin
                        bus_req.wr_data <= deq_cmd.operand;
                    end else begin
                        bus_req.wr_data <= '0;
                    end
                end
            end
            S_REQ, S_ADD_WR: begin
                if (add_rd_done) begin
                    // Old word goes back in the response, the sum goes to memory
                    data_q <= rd_data;
                    bus_req.wr_en <= 1'b1;
                    bus_req.rd_en <= 1'b0;
                    bus_req.wr_data <= rd_data + cmd_q.operand;
                end else if (ack_vld) begin
                    // Memory returns zero on a write ack
                    if (state == S_REQ) begin
                        data_q <= rd_data;
                    end
                end else if (tmo_hit) begin
                    err_q <= 1'b1;
                    data_q <= '0;
                end
            end
            S_RECOVER: begin
                rsp.op <= cmd_q.op;
                rsp.error <= err_q;
                rsp.data <= data_q;
            end
            default: begin
            end
        endcase
    end

    // Request must be held until the memory answers or we give up
    a_bus_req_held: assert property (
        @(posedge clk) disable iff (reset)
        (req_vld && !ack_vld && !tmo_hit) |=> (req_vld && $stable(bus_req))
    ) else $error("mem_access_ctrl: bus request changed while waiting for ack");

    a_rsp_single: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid
    ) else $error("mem_access_ctrl: rsp_valid high for two cycles");

endmodule

// ==== hw/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo
    import mem_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cmd_valid,
    input  mem_cmd_t cmd,
    input  logic     deq_pop,
    output logic     cmd_full,
    output logic     deq_valid,
    output mem_cmd_t deq_cmd
);

    mem_cmd_t                 entries [CMD_FIFO_DEPTH];
    logic [CMD_PTR_WIDTH-1:0] wr_ptr;
    logic [CMD_PTR_WIDTH-1:0] rd_ptr;
    logic [CMD_CNT_WIDTH-1:0] count;
    logic                     do_push;
    logic                     do_pop;

    function automatic logic [CMD_PTR_WIDTH-1:0] ptr_inc(input logic [CMD_PTR_WIDTH-1:0] ptr);
        if (ptr == CMD_PTR_WIDTH'(CMD_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign cmd_full = (count == CMD_CNT_WIDTH'(CMD_FIFO_DEPTH));
    assign deq_valid = (count != '0);
    assign deq_cmd = entries[rd_ptr];

    assign do_push = cmd_valid && !cmd_full;
    assign do_pop = deq_pop && deq_valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        cmd_valid |-> !cmd_full
    ) else $error("cmd_fifo: command pushed while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        deq_pop |-> deq_valid
    ) else $error("cmd_fifo: pop while empty");

endmodule

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top
    import reg_bus_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cmd_valid,
    input  mem_cmd_t cmd,
    input  logic     ack_fault,
    output logic     cmd_full,
    output logic     rsp_valid,
    output mem_rsp_t rsp
);

    // Queue to controller
    logic     deq_valid;
    mem_cmd_t deq_cmd;
    logic     deq_pop;

    // Controller to memory
    logic                  req_vld;
    bus_req_t              bus_req;
    logic                  ack_vld;
    logic [DATA_WIDTH-1:0] rd_data;

    cmd_fifo u_cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .deq_pop   (deq_pop),
        .cmd_full  (cmd_full),
        .deq_valid (deq_valid),
        .deq_cmd   (deq_cmd)
    );

    mem_access_ctrl u_mem_access_ctrl (
        .clk       (clk),
        .reset     (reset),
        .deq_valid (deq_valid),
        .deq_cmd   (deq_cmd),
        .ack_vld   (ack_vld),
        .rd_data   (rd_data),
        .deq_pop   (deq_pop),
        .req_vld   (req_vld),
        .bus_req   (bus_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    ext_mem u_ext_mem (
        .clk       (clk),
        .reset     (reset),
        .req_vld   (req_vld),
        .bus_req   (bus_req),
        .ack_fault (ack_fault),
        .ack_vld   (ack_vld),
        .rd_data   (rd_data)
    );

endmodule

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys
    import reg_bus_pkg::*;
    import mem_cmd_pkg::*;
();

    // Command counts per test, used for the cycle limit
    localparam int N_FILL = MEM_ENTRIES;
    localparam int N_RAND = 200;
    localparam int N_ADD = 60;
    localparam int N_BURST = 5;
    localparam int N_FAULT = 12;
    localparam int N_RST = 8;
    localparam int N_ABANDON = CMD_FIFO_DEPTH + 1;
    localparam int N_TOTAL = N_FILL + N_RAND + N_ADD + N_BURST + 2 * N_FAULT + 2 * N_RST
                             + N_ABANDON;
    localparam int CYCLE_LIMIT = N_TOTAL * (8 + 2 * ACK_TIMEOUT + 2) + 100;

    logic     clk;
    logic     reset;
    logic     cmd_valid;
    mem_cmd_t cmd;
    logic     ack_fault;
    logic     cmd_full;
    logic     rsp_valid;
    mem_rsp_t rsp;

    logic [DATA_WIDTH-1:0] model [MEM_ENTRIES];
    mem_rsp_t              expected_q [$];
    logic [ADDR_WIDTH-1:0] touched_q [$];
    logic [31:0]           rng_state = 32'h12bf_b08d;
    string                 test_name = "reset";
    int                    cycle_cnt = 0;
    int                    n_pushed = 0;
    int                    n_rsp = 0;

    mem_subsys_top u_mem_subsys_top (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .ack_fault (ack_fault),
        .cmd_full  (cmd_full),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input string test, input mem_rsp_t exp, input mem_rsp_t act);
        if (act !== exp) begin
            fail_run($sformatf(
                "Mismatch in %s: expected op=%0d err=%0b data=%h, actual op=%0d err=%0b data=%h",
                test, exp.op, exp.error, exp.data, act.op, act.error, act.data));
        end
    endtask

    task automatic check_level(input string test, input string sig, input logic exp,
                               input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: %s expected %0b, actual %0b",
                test, sig, exp, act));
        end
    endtask

    // One clock at the falling edge, where every DUT output is settled
    task automatic tick();
        mem_rsp_t exp;
        @(negedge clk);
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout in %s after %0d cycles, %0d responses never arrived",
                test_name, cycle_cnt, expected_q.size()));
        end
        if (rsp_valid) begin
            if (expected_q.size() == 0) begin
                fail_run($sformatf("Response in %s arrived with no command outstanding",
                    test_name));
            end else begin
                exp = expected_q.pop_front();
                check_rsp(test_name, exp, rsp);
                n_rsp++;
            end
        end
    endtask

    // Predict the response and update the model in command order
    task automatic push_cmd(input mem_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] operand);
        mem_rsp_t exp;
        while (cmd_full) begin
            tick();
        end
        exp.op = op;
        exp.error = ack_fault;
        exp.data = '0;
        // A missing ack leaves memory untouched
        if (!ack_fault) begin
            case (op)
                OP_READ:  exp.data = model[addr];
                OP_WRITE: model[addr] = operand;
                default: begin
                    exp.data = model[addr];
                    model[addr] = model[addr] + operand;
                end
            endcase
        end
        expected_q.push_back(exp);
        cmd_valid = 1'b1;
        cmd.op = op;
        cmd.addr = addr;
        cmd.operand = operand;
        n_pushed++;
        tick();
        cmd_valid = 1'b0;
    endtask

    task automatic drain();
        while (expected_q.size() != 0) begin
            tick();
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        tick();
        tick();
        reset = 1'b0;
        check_level(test_name, "rsp_valid", 1'b0, rsp_valid);
        check_level(test_name, "cmd_full", 1'b0, cmd_full);
    endtask

    initial begin
        logic [31:0]           r;
        logic [ADDR_WIDTH-1:0] a;

        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        ack_fault = 1'b0;
        apply_reset();

        test_name = "fill";
        for (int i = 0; i < N_FILL; i++) begin
            push_cmd(OP_WRITE, ADDR_WIDTH'(i), next_rand());
        end
        drain();

        test_name = "random_rw";
        for (int i = 0; i < N_RAND; i++) begin
            r = next_rand();
            push_cmd(r[30] ? OP_WRITE : OP_READ, r[16 +: ADDR_WIDTH], next_rand());
        end
        drain();

        // Roughly one read for every two adds
        test_name = "read_add_write";
        for (int i = 0; i < N_ADD; i++) begin
            r = next_rand();
            push_cmd((r[31:28] < 4'd5) ? OP_READ : OP_ADD, r[16 +: ADDR_WIDTH], next_rand());
        end
        drain();

        // Controller busy on an add while four more commands fill the queue
        test_name = "back_pressure";
        n_pushed = 0;
        n_rsp = 0;
        push_cmd(OP_ADD, ADDR_WIDTH'(next_rand() >> 16), next_rand());
        tick();
        for (int i = 1; i < N_BURST; i++) begin
            r = next_rand();
            push_cmd(r[30] ? OP_WRITE : OP_READ, r[16 +: ADDR_WIDTH], next_rand());
            check_level(test_name, "cmd_full",
                (n_pushed - n_rsp - 1) == CMD_FIFO_DEPTH, cmd_full);
        end
        drain();

        test_name = "ack_fault";
        ack_fault = 1'b1;
        for (int i = 0; i < N_FAULT; i++) begin
            r = next_rand();
            a = r[16 +: ADDR_WIDTH];
            touched_q.push_back(a);
            push_cmd(mem_op_e'(r[31:30] % 3), a, next_rand());
        end
        drain();
        ack_fault = 1'b0;
        test_name = "ack_fault_readback";
        foreach (touched_q[i]) begin
            push_cmd(OP_READ, touched_q[i], '0);
        end
        drain();

        test_name = "mid_reset";
        touched_q.delete();
        for (int i = 0; i < N_RST; i++) begin
            a = ADDR_WIDTH'(next_rand() >> 16);
            touched_q.push_back(a);
            push_cmd(OP_WRITE, a, next_rand());
        end
        drain();
        // One read in flight and a full queue behind it, all abandoned by the reset
        n_pushed = 0;
        n_rsp = 0;
        for (int i = 0; i < N_ABANDON; i++) begin
            push_cmd(OP_READ, touched_q[i], '0);
        end
        check_level(test_name, "cmd_full",
            (n_pushed - n_rsp - 1) == CMD_FIFO_DEPTH, cmd_full);
        apply_reset();
        expected_q.delete();
        foreach (touched_q[i]) begin
            push_cmd(OP_READ, touched_q[i], '0);
        end
        drain();

        // A stray response after the last one would show up here
        repeat (4) begin
            tick();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== compile.f ====
common/reg_bus_pkg.sv
common/mem_cmd_pkg.sv
hw/ext_mem/ext_mem.sv
hw/mem_ctrl/mem_access_ctrl.sv
hw/cmd_fifo.sv
hw/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

dependencies: {}

sources:
  # Shared packages first, in dependency order
  - common/reg_bus_pkg.sv
  - common/mem_cmd_pkg.sv
  # Design
  - hw/ext_mem/ext_mem.sv
  - hw/mem_ctrl/mem_access_ctrl.sv
  - hw/cmd_fifo.sv
  - hw/mem_subsys_top.sv
  # Testbench, top module tb_mem_subsys
  - target: simulation
    files:
      - sim/tb_mem_subsys.sv
